//--- filelist.f
+incdir+tests
design/scc_pkg.sv
design/scc_regs.sv
design/scc_tx.sv
design/scc_rx.sv
design/scc_irq.sv
design/scc.sv
tests/tb_scc.sv

//--- Makefile
# verilator simulation of the scc testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_scc: filelist.f design/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing --assert -Wno-fatal --top-module tb_scc -f filelist.f

# pass only when the pass line shows up in the simulation output
run: obj_dir/Vtb_scc
	@out="$$(./obj_dir/Vtb_scc)"; echo "$$out"; \
		echo "$$out" | grep -q -F '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing -Wall --top-module tb_scc -f filelist.f

clean:
	rm -rf obj_dir

//--- tests/tb_scc_tasks.svh
`ifndef TB_SCC_TASKS_SVH
`define TB_SCC_TASKS_SVH
`default_nettype none

// compare and count, values shown in hex
task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] got);
	assert (got === exp) begin
		pass_cnt++;
	end else begin
		$display("FAIL %s expected %02h got %02h", name, exp, got);
		fail_cnt++;
	end
endtask

task automatic report_timeout(input string what);
	$display("timeout while waiting for %s", what);
	fail_cnt++;
endtask

// cs held for exactly one rising edge
task automatic bus_write(input logic port, input logic [7:0] data);
	@(negedge clk);
	cs = 1'b1;
	we = 1'b1;
	rs = port;
	wdata = data;
	@(negedge clk);
	cs = 1'b0;
	we = 1'b0;
endtask

task automatic bus_read(input logic port, output logic [7:0] data);
	@(negedge clk);
	cs = 1'b1;
	we = 1'b0;
	rs = port;
	// read data is combinational, settled well before the rising edge
	#5;
	data = rdata;
	@(negedge clk);
	cs = 1'b0;
endtask

// index 8 and up sets the point high command through bit 3
task automatic reg_write(input logic [3:0] idx, input logic [7:0] data);
	if (idx != 4'd0) begin
		bus_write(1'b0, {4'd0, idx});
	end
	bus_write(1'b0, data);
endtask

task automatic reg_read(input logic [3:0] idx, output logic [7:0] data);
	if (idx != 4'd0) begin
		bus_write(1'b0, {4'd0, idx});
	end
	bus_read(1'b0, data);
endtask

// wr0 command field sits in bits 5:3
task automatic issue_cmd(input logic [2:0] cmd);
	bus_write(1'b0, {2'b00, cmd, 3'b000});
endtask

task automatic wait_irq(input logic level, input int limit);
	int n;
	n = 0;
	while (irq_n !== level && n < limit) begin
		@(negedge clk);
		n++;
	end
	if (irq_n !== level) begin
		report_timeout($sformatf("o_irq_n to become %0d", level));
	end
endtask

// polls rr0, pointer must already be 0
task automatic wait_rr0(input int pos, input logic level, input int limit);
	logic [7:0] v;
	int n;
	n = 0;
	bus_read(1'b0, v);
	while (v[pos] !== level && n < limit) begin
		bus_read(1'b0, v);
		n++;
	end
	if (v[pos] !== level) begin
		report_timeout($sformatf("rr0 bit %0d to become %0d", pos, level));
	end
endtask

// start bit, data lsb first, stop bit
task automatic send_frame(input logic [7:0] data);
	logic [9:0] frame;
	int i;
	frame = {1'b1, data, 1'b0};
	for (i = 0; i < 10; i++) begin
		@(negedge clk);
		rxd = frame[i];
		repeat (BIT_CLKS - 1) @(negedge clk);
	end
endtask

task automatic decode_txd(output logic [7:0] data);
	logic [7:0] v;
	int n;
	int i;
	n = 0;
	data = 8'h00;
	while (txd !== 1'b0 && n < 20) begin
		@(negedge clk);
		n++;
	end
	if (txd !== 1'b0) begin
		report_timeout("start bit on o_txd");
	end else begin
		// status poll fits inside the start bit
		bus_read(1'b0, v);
		check_val("o_rdata (rr0 tx_empty)", 8'h00, {7'd0, v[2]});
		// now at mid start bit
		repeat (BIT_CLKS / 2 - 2) @(negedge clk);
		check_val("o_txd start bit", 8'h00, {7'd0, txd});
		for (i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge clk);
			data[i] = txd;
		end
		repeat (BIT_CLKS) @(negedge clk);
		check_val("o_txd stop bit", 8'h01, {7'd0, txd});
	end
endtask

// receive one random byte, check irq against the expectation, then read it
task automatic rx_irq_byte(input logic irq_expected);
	logic [7:0] b;
	logic [7:0] got;
	b = 8'($random(seed));
	send_frame(b);
	wait_rr0(0, 1'b1, 20);
	check_val("o_irq_n", {7'd0, !irq_expected}, {7'd0, irq_n});
	bus_read(1'b1, got);
	check_val("o_rdata (rx data)", b, got);
	wait_irq(1'b1, 4);
endtask

`default_nettype wire
`endif

//--- tests/tb_scc.sv
`timescale 1ns/100ps
`default_nettype none

module tb_scc;

	// time constant 6 gives 8 clocks per bit
	localparam int BIT_CLKS = 8;

	logic clk;
	logic reset_hw;
	logic cs;
	logic we;
	logic rs;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic irq_n;
	logic rxd;
	logic txd;
	logic rts;
	logic dcd;

	integer seed;
	int pass_cnt;
	int fail_cnt;
	int fail_mark;

	scc #(
		.SYNC_STAGES(2)
	) dut0 (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_cs(cs),
		.i_we(we),
		.i_rs(rs),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_irq_n(irq_n),
		.i_rxd(rxd),
		.o_txd(txd),
		.o_rts(rts),
		.i_dcd(dcd)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// one summary line per test
	task automatic test_done(input string name);
		if (fail_cnt == fail_mark) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, fail_cnt - fail_mark);
		end
		fail_mark = fail_cnt;
	endtask

	initial begin
		logic [7:0] v;
		logic [7:0] b;
		logic [7:0] got;
		seed = 32'h8aa7_6c92;
		pass_cnt = 0;
		fail_cnt = 0;
		fail_mark = 0;
		cs = 1'b0;
		we = 1'b0;
		rs = 1'b0;
		wdata = 8'h00;
		// serial line idles at mark
		rxd = 1'b1;
		dcd = 1'b0;
		reset_hw = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset_hw = 1'b0;

		// tx empty, nothing received, dcd low
		bus_read(1'b0, v);
		check_val("o_rdata (rr0)", 8'h04, v);
		reg_write(4'd12, 8'h06);
		reg_write(4'd13, 8'h00);
		reg_read(4'd12, v);
		check_val("o_rdata (wr12)", 8'h06, v);
		reg_read(4'd13, v);
		check_val("o_rdata (wr13)", 8'h00, v);
		// pointer fell back to 0 after the readback
		bus_read(1'b0, v);
		check_val("o_rdata (rr0)", 8'h04, v);
		test_done("register access");

		reg_write(4'd5, 8'h08);
		b = 8'($random(seed));
		bus_write(1'b1, b);
		decode_txd(got);
		check_val("o_txd data", b, got);
		wait_rr0(2, 1'b1, 40);
		test_done("transmit");

		reg_write(4'd3, 8'h01);
		b = 8'($random(seed));
		send_frame(b);
		wait_rr0(0, 1'b1, 20);
		check_val("o_rts", 8'h01, {7'd0, rts});
		bus_read(1'b1, got);
		check_val("o_rdata (rx data)", b, got);
		bus_read(1'b0, v);
		check_val("o_rdata (rr0)", 8'h04, v);
		check_val("o_rts", 8'h00, {7'd0, rts});
		test_done("receive");

		// every character interrupts
		reg_write(4'd9, 8'h08);
		reg_write(4'd1, 8'h10);
		rx_irq_byte(1'b1);
		rx_irq_byte(1'b1);
		// first character only, armed by rx_int_next
		reg_write(4'd1, 8'h08);
		issue_cmd(3'b100);
		rx_irq_byte(1'b1);
		rx_irq_byte(1'b0);
		issue_cmd(3'b100);
		rx_irq_byte(1'b1);
		reg_write(4'd1, 8'h00);
		test_done("receive interrupt modes");

		reg_write(4'd1, 8'h02);
		bus_write(1'b1, 8'($random(seed)));
		// full frame plus launch latency
		wait_irq(1'b0, 120);
		reg_read(4'd3, v);
		check_val("o_rdata (rr3)", 8'h10, v);
		issue_cmd(3'b101);
		wait_irq(1'b1, 4);
		reg_read(4'd3, v);
		check_val("o_rdata (rr3)", 8'h00, v);
		reg_write(4'd1, 8'h00);
		test_done("transmit interrupt");

		reg_write(4'd15, 8'h08);
		reg_write(4'd1, 8'h01);
		@(negedge clk);
		dcd = 1'b1;
		wait_irq(1'b0, 4);
		reg_read(4'd3, v);
		check_val("o_rdata (rr3)", 8'h08, v);
		bus_read(1'b0, v);
		check_val("o_rdata (rr0)", 8'h0c, v);
		// latch is closed, so rr0 keeps the captured level
		@(negedge clk);
		dcd = 1'b0;
		repeat (3) @(negedge clk);
		bus_read(1'b0, v);
		check_val("o_rdata (rr0)", 8'h0c, v);
		issue_cmd(3'b010);
		wait_irq(1'b1, 4);
		bus_read(1'b0, v);
		check_val("o_rdata (rr0)", 8'h04, v);
		reg_write(4'd15, 8'h00);
		reg_write(4'd1, 8'h00);
		test_done("dcd external status");

		$display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	`include "tb_scc_tasks.svh"

endmodule

`default_nettype wire

//--- design/scc.sv
`timescale 1ns/100ps
`default_nettype none

module scc #(
	parameter int unsigned SYNC_STAGES = 2
) (
	input wire clk,
	input wire reset_hw,
	// cpu bus, single cycle strobe
	input wire i_cs,
	input wire i_we,
	input wire i_rs,
	input wire scc_pkg::byte_t i_wdata,
	output scc_pkg::byte_t o_rdata,
	output logic o_irq_n,
	// serial line and modem pins
	input wire i_rxd,
	output logic o_txd,
	output logic o_rts,
	input wire i_dcd
);

	scc_pkg::chan_ctrl_t ctrl;
	scc_pkg::chan_cmd_t cmd;
	scc_pkg::irq_pend_t pend;
	scc_pkg::byte_t tx_data;
	scc_pkg::byte_t rx_data;
	logic tx_req;
	logic tx_ack;
	logic tx_empty;
	logic rx_valid;
	logic rx_avail;
	logic dcd_status;

	scc_regs u_regs (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_cs(i_cs),
		.i_we(i_we),
		.i_rs(i_rs),
		.i_wdata(i_wdata),
		.i_rx_valid(rx_valid),
		.i_rx_data(rx_data),
		.i_tx_ack(tx_ack),
		.i_tx_empty(tx_empty),
		.i_pend(pend),
		.i_dcd_status(dcd_status),
		.o_rdata(o_rdata),
		.o_ctrl(ctrl),
		.o_cmd(cmd),
		.o_tx_req(tx_req),
		.o_tx_data(tx_data),
		.o_rx_avail(rx_avail),
		.o_rts(o_rts)
	);

	scc_tx u_tx (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_ctrl(ctrl),
		.i_cmd(cmd),
		.i_tx_req(tx_req),
		.i_tx_data(tx_data),
		.o_tx_ack(tx_ack),
		.o_tx_empty(tx_empty),
		.o_txd(o_txd)
	);

	scc_rx #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_rx (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_ctrl(ctrl),
		.i_cmd(cmd),
		.i_rxd(i_rxd),
		.o_rx_valid(rx_valid),
		.o_rx_data(rx_data)
	);

	scc_irq u_irq (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_ctrl(ctrl),
		.i_cmd(cmd),
		.i_rx_avail(rx_avail),
		.i_tx_empty(tx_empty),
		.i_dcd(i_dcd),
		.o_pend(pend),
		.o_dcd_status(dcd_status),
		.o_irq_n(o_irq_n)
	);

endmodule

`default_nettype wire

//--- design/scc_irq.sv
`timescale 1ns/100ps
`default_nettype none

module scc_irq (
	input wire clk,
	input wire reset_hw,
	input wire scc_pkg::chan_ctrl_t i_ctrl,
	input wire scc_pkg::chan_cmd_t i_cmd,
	input wire i_rx_avail,
	input wire i_tx_empty,
	input wire i_dcd,
	output scc_pkg::irq_pend_t o_pend,
	output logic o_dcd_status,
	output logic o_irq_n
);

	logic first_q;
	logic rx_pend_q;
	logic tx_pend_q;
	logic ext_pend_q;
	logic tx_prev;
	logic latch_open;
	logic dcd_latch;
	logic rx_cond;
	logic tx_rise;
	logic do_latch;

	// mode 10 every char, mode 01 only the first after arming
	assign rx_cond = i_ctrl.rx_en & i_rx_avail &
		((i_ctrl.rx_int_mode == 2'b10) | ((i_ctrl.rx_int_mode == 2'b01) & first_q));
	assign tx_rise = i_tx_empty & ~tx_prev;
	// an enabled dcd change closes the open latch
	assign do_latch = latch_open & i_ctrl.dcd_ie & (i_dcd != dcd_latch);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			first_q <= 1'b1;
			rx_pend_q <= 1'b0;
		end else if (i_cmd.chan_reset) begin
			first_q <= 1'b1;
			rx_pend_q <= 1'b0;
		end else begin
			// rx_int_next rearms first-char mode
			if (i_cmd.rx_int_next) begin
				first_q <= 1'b1;
			end else if (i_cmd.data_read) begin
				first_q <= 1'b0;
			end
			rx_pend_q <= rx_cond;
		end
	end

	// tx pending is an edge latch on the end of a frame
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			tx_prev <= 1'b1;
			tx_pend_q <= 1'b0;
		end else begin
			tx_prev <= i_tx_empty;
			if (i_cmd.chan_reset || i_cmd.data_write || i_cmd.reset_tx_ip || !i_ctrl.tx_en) begin
				tx_pend_q <= 1'b0;
			end else if (tx_rise && i_ctrl.tx_ie) begin
				tx_pend_q <= 1'b1;
			end
		end
	end

	// latch follows dcd while open and freezes on a change
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			latch_open <= 1'b1;
			dcd_latch <= 1'b0;
			ext_pend_q <= 1'b0;
		end else if (i_cmd.chan_reset || i_cmd.reset_ext) begin
			latch_open <= 1'b1;
			dcd_latch <= i_dcd;
			ext_pend_q <= 1'b0;
		end else begin
			if (latch_open) begin
				dcd_latch <= i_dcd;
			end
			if (do_latch) begin
				latch_open <= 1'b0;
				ext_pend_q <= ext_pend_q | i_ctrl.ext_ie;
			end
		end
	end

	assign o_pend = '{rx: rx_pend_q, tx: tx_pend_q, ext: ext_pend_q};
	assign o_dcd_status = i_ctrl.dcd_ie ? dcd_latch : i_dcd;
	assign o_irq_n = ~(i_ctrl.mie & (rx_pend_q | tx_pend_q | ext_pend_q));

	// master enable in wr9 masks all sources regardless of pending state
	a_mie_mask: assert property (@(posedge clk) disable iff (reset_hw)
		!i_ctrl.mie |-> o_irq_n);

endmodule

`default_nettype wire

//--- design/scc_rx.sv
`timescale 1ns/100ps
`default_nettype none

module scc_rx #(
	// two stages minimum
	parameter int unsigned SYNC_STAGES = 2
) (
	input wire clk,
	input wire reset_hw,
	input wire scc_pkg::chan_ctrl_t i_ctrl,
	input wire scc_pkg::chan_cmd_t i_cmd,
	input wire i_rxd,
	output logic o_rx_valid,
	output scc_pkg::byte_t o_rx_data
);

	logic [SYNC_STAGES-1:0] sync_q;
	logic rxd_s;
	logic rxd_prev;
	scc_pkg::ser_state_e state;
	logic [16:0] bit_cnt;
	logic [16:0] reload;
	logic [16:0] half;
	logic [2:0] bit_idx;
	scc_pkg::byte_t shreg;
	logic bit_end;

	assign rxd_s = sync_q[SYNC_STAGES-1];
	assign reload = {1'b0, i_ctrl.time_const} + 17'd1;
	// half a period after the edge lands in the middle of the start bit
	assign half = {2'b00, i_ctrl.time_const[15:1]};
	assign bit_end = (bit_cnt == '0);

	// rxd is asynchronous, line idles high
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			sync_q <= '1;
			rxd_prev <= 1'b1;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], i_rxd};
			rxd_prev <= rxd_s;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			state <= scc_pkg::st_idle;
			bit_cnt <= '0;
			bit_idx <= '0;
			o_rx_valid <= 1'b0;
		end else if (i_cmd.chan_reset || !i_ctrl.rx_en) begin
			state <= scc_pkg::st_idle;
			bit_cnt <= '0;
			bit_idx <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0;
			if (state != scc_pkg::st_idle) begin
				bit_cnt <= bit_end ? reload : bit_cnt - 17'd1;
			end
			case (state)
				scc_pkg::st_idle: begin
					// falling edge, possible start bit
					if (rxd_prev && !rxd_s) begin
						bit_cnt <= half;
						state <= scc_pkg::st_start;
					end
				end
				scc_pkg::st_start: begin
					if (bit_end) begin
						// high at mid-bit means a glitch, not a start
						bit_idx <= '0;
						state <= rxd_s ? scc_pkg::st_idle : scc_pkg::st_data;
					end
				end
				scc_pkg::st_data: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= scc_pkg::st_stop;
						end
					end
				end
				scc_pkg::st_stop: begin
					if (bit_end) begin
						// framing error drops the character
						o_rx_valid <= rxd_s;
						state <= scc_pkg::st_idle;
					end
				end
				default: state <= scc_pkg::st_idle;
			endcase
		end
	end

	// shift in from the top so the first bit ends up in bit 0
	always_ff @(posedge clk) begin
		if (state == scc_pkg::st_data && bit_end) begin
			shreg <= {rxd_s, shreg[7:1]};
		end
	end

	assign o_rx_data = shreg;

	a_valid_pulse: assert property (@(posedge clk) disable iff (reset_hw)
		o_rx_valid |=> !o_rx_valid);

endmodule

`default_nettype wire

//--- design/scc_tx.sv
`timescale 1ns/100ps
`default_nettype none

module scc_tx (
	input wire clk,
	input wire reset_hw,
	input wire scc_pkg::chan_ctrl_t i_ctrl,
	input wire scc_pkg::chan_cmd_t i_cmd,
	input wire i_tx_req,
	input wire scc_pkg::byte_t i_tx_data,
	output logic o_tx_ack,
	output logic o_tx_empty,
	output logic o_txd
);

	scc_pkg::ser_state_e state;
	logic [16:0] bit_cnt;
	logic [16:0] reload;
	logic [2:0] bit_idx;
	scc_pkg::byte_t shreg;
	logic bit_end;
	logic accept;
	logic launch;

	// one bit is time constant + 2 clocks, counted down to zero
	assign reload = {1'b0, i_ctrl.time_const} + 17'd1;
	assign bit_end = (bit_cnt == '0);
	// take the byte, then start once the request has dropped
	assign accept = (state == scc_pkg::st_idle) & i_tx_req & ~o_tx_ack & i_ctrl.tx_en;
	assign launch = (state == scc_pkg::st_idle) & o_tx_ack & ~i_tx_req;
	assign o_tx_empty = (state == scc_pkg::st_idle) & ~o_tx_ack & ~i_tx_req;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			state <= scc_pkg::st_idle;
			o_tx_ack <= 1'b0;
			o_txd <= 1'b1;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else if (i_cmd.chan_reset) begin
			state <= scc_pkg::st_idle;
			o_tx_ack <= 1'b0;
			o_txd <= 1'b1;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else begin
			if (accept) begin
				o_tx_ack <= 1'b1;
			end
			if (state != scc_pkg::st_idle) begin
				bit_cnt <= bit_end ? reload : bit_cnt - 17'd1;
			end
			case (state)
				scc_pkg::st_idle: begin
					if (launch) begin
						o_tx_ack <= 1'b0;
						o_txd <= 1'b0;
						bit_cnt <= reload;
						state <= scc_pkg::st_start;
					end
				end
				scc_pkg::st_start: begin
					if (bit_end) begin
						o_txd <= shreg[0];
						bit_idx <= '0;
						state <= scc_pkg::st_data;
					end
				end
				scc_pkg::st_data: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							o_txd <= 1'b1;
							state <= scc_pkg::st_stop;
						end else begin
							// lsb first
							o_txd <= shreg[bit_idx + 3'd1];
							bit_idx <= bit_idx + 3'd1;
						end
					end
				end
				scc_pkg::st_stop: begin
					if (bit_end) begin
						state <= scc_pkg::st_idle;
					end
				end
				default: state <= scc_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			shreg <= i_tx_data;
		end
	end

	// line rests at mark between frames
	a_idle_mark: assert property (@(posedge clk) disable iff (reset_hw)
		(state == scc_pkg::st_idle) |-> o_txd);

endmodule

`default_nettype wire

//--- design/scc_regs.sv
`timescale 1ns/100ps
`default_nettype none

module scc_regs (
	input wire clk,
	input wire reset_hw,
	input wire i_cs,
	input wire i_we,
	input wire i_rs,
	input wire scc_pkg::byte_t i_wdata,
	input wire i_rx_valid,
	input wire scc_pkg::byte_t i_rx_data,
	input wire i_tx_ack,
	input wire i_tx_empty,
	input wire scc_pkg::irq_pend_t i_pend,
	input wire i_dcd_status,
	output scc_pkg::byte_t o_rdata,
	output scc_pkg::chan_ctrl_t o_ctrl,
	output scc_pkg::chan_cmd_t o_cmd,
	output logic o_tx_req,
	output scc_pkg::byte_t o_tx_data,
	output logic o_rx_avail,
	output logic o_rts
);

	logic ctl_acc;
	logic ctl_wr;
	logic wr0_wr;
	logic data_wr;
	logic data_rd;
	logic chan_reset;
	scc_pkg::wr0_cmd_e wr0_cmd;
	scc_pkg::reg_index_t rindex;
	scc_pkg::reg_index_t rindex_pend;
	scc_pkg::chan_ctrl_t ctrl_q;
	scc_pkg::byte_t wr15_q;
	scc_pkg::byte_t rx_data_q;
	scc_pkg::byte_t tx_data_q;
	logic rx_avail_q;
	logic tx_req_q;
	scc_pkg::byte_t rr0;
	scc_pkg::byte_t rr1;
	scc_pkg::byte_t rr3;

	// rs low is the control port, high the data port
	assign ctl_acc = i_cs & ~i_rs;
	assign ctl_wr = ctl_acc & i_we;
	assign wr0_wr = ctl_wr & (rindex == 4'd0);
	assign data_wr = i_cs & i_we & i_rs;
	assign data_rd = i_cs & ~i_we & i_rs;
	assign wr0_cmd = scc_pkg::wr0_cmd_e'(i_wdata[5:3]);
	// wr9 bits 7:6 of 10 or 11 both reset channel a
	assign chan_reset = ctl_wr & (rindex == 4'd9) & i_wdata[7];

	always_comb begin
		o_cmd = '0;
		o_cmd.chan_reset = chan_reset;
		o_cmd.data_write = data_wr;
		o_cmd.data_read = data_rd;
		if (wr0_wr) begin
			case (wr0_cmd)
				scc_pkg::cmd_reset_ext: o_cmd.reset_ext = 1'b1;
				scc_pkg::cmd_rx_int_next: o_cmd.rx_int_next = 1'b1;
				scc_pkg::cmd_reset_tx_ip: o_cmd.reset_tx_ip = 1'b1;
				// no under-service chain here, reset ius is a no-op
				scc_pkg::cmd_reset_ius: ;
				default: ;
			endcase
		end
	end

	// wr0 loads the next pointer, any other control access returns it to 0
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex_pend <= '0;
		end else if (ctl_acc) begin
			if (wr0_wr) begin
				rindex_pend <= {wr0_cmd == scc_pkg::cmd_point_high, i_wdata[2:0]};
			end else begin
				rindex_pend <= '0;
			end
		end
	end

	// pointer moves only between accesses so read data stays put while cs is held
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex <= '0;
		end else if (!i_cs) begin
			rindex <= rindex_pend;
		end
	end

	// write registers, time constant survives a channel reset
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			ctrl_q <= '0;
			wr15_q <= '0;
		end else if (chan_reset) begin
			ctrl_q <= '{time_const: ctrl_q.time_const, default: '0};
			wr15_q <= '0;
		end else if (ctl_wr) begin
			case (rindex)
				4'd1: begin
					ctrl_q.rx_int_mode <= i_wdata[4:3];
					ctrl_q.tx_ie <= i_wdata[1];
					ctrl_q.ext_ie <= i_wdata[0];
				end
				4'd3: ctrl_q.rx_en <= i_wdata[0];
				4'd5: ctrl_q.tx_en <= i_wdata[3];
				4'd9: ctrl_q.mie <= i_wdata[3];
				4'd12: ctrl_q.time_const[7:0] <= i_wdata;
				4'd13: ctrl_q.time_const[15:8] <= i_wdata;
				4'd15: begin
					wr15_q <= i_wdata;
					ctrl_q.dcd_ie <= i_wdata[3];
				end
				default: ;
			endcase
		end
	end

	// a new byte overwrites one still waiting
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rx_avail_q <= 1'b0;
		end else if (chan_reset) begin
			rx_avail_q <= 1'b0;
		end else if (i_rx_valid) begin
			rx_avail_q <= 1'b1;
		end else if (data_rd) begin
			rx_avail_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rx_valid) begin
			rx_data_q <= i_rx_data;
		end
	end

	// four-phase request towards the transmitter
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			tx_req_q <= 1'b0;
		end else if (chan_reset) begin
			tx_req_q <= 1'b0;
		end else if (tx_req_q && i_tx_ack) begin
			tx_req_q <= 1'b0;
		end else if (data_wr && i_tx_empty) begin
			tx_req_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (data_wr && i_tx_empty) begin
			tx_data_q <= i_wdata;
		end
	end

	always_comb begin
		rr0 = '0;
		rr0[scc_pkg::RR0_RX_AVAIL] = rx_avail_q;
		rr0[scc_pkg::RR0_TX_EMPTY] = i_tx_empty;
		rr0[scc_pkg::RR0_DCD] = i_dcd_status;
	end

	// all sent
	assign rr1 = {7'd0, i_tx_empty};
	assign rr3 = {2'b00, i_pend.rx, i_pend.tx, i_pend.ext, 3'b000};

	always_comb begin
		if (i_rs) begin
			o_rdata = rx_data_q;
		end else begin
			case (rindex)
				4'd0: o_rdata = rr0;
				4'd1: o_rdata = rr1;
				4'd3: o_rdata = rr3;
				4'd12: o_rdata = ctrl_q.time_const[7:0];
				4'd13: o_rdata = ctrl_q.time_const[15:8];
				4'd15: o_rdata = wr15_q;
				default: o_rdata = '0;
			endcase
		end
	end

	assign o_ctrl = ctrl_q;
	assign o_tx_req = tx_req_q;
	assign o_tx_data = tx_data_q;
	assign o_rx_avail = rx_avail_q;
	// rts tracks a waiting character
	assign o_rts = rx_avail_q;

	// request only withdrawn once the transmitter has answered
	a_req_hold: assert property (@(posedge clk) disable iff (reset_hw)
		$fell(tx_req_q) |-> ($past(i_tx_ack) || $past(chan_reset)));

	// a byte written while a frame is in flight is lost
	a_wr_busy: assert property (@(posedge clk) disable iff (reset_hw)
		data_wr |-> i_tx_empty)
		else $warning("data write while transmitter busy, byte dropped");

endmodule

`default_nettype wire

//--- design/scc_pkg.sv
`default_nettype none

package scc_pkg;

	// one data or register byte
	typedef logic [7:0] byte_t;
	// indirect register pointer, bit 3 comes from point high
	typedef logic [3:0] reg_index_t;
	// wr13:wr12 baud divisor, one bit lasts this value plus two clocks
	typedef logic [15:0] time_const_t;

	// command field of wr0, bits 5:3
	typedef enum logic [2:0] {
		cmd_null        = 3'b000,
		cmd_point_high  = 3'b001,
		cmd_reset_ext   = 3'b010,
		cmd_rx_int_next = 3'b100,
		cmd_reset_tx_ip = 3'b101,
		cmd_reset_ius   = 3'b111
	} wr0_cmd_e;

	// frame position, shared by serializer and deserializer
	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} ser_state_e;

	// channel configuration decoded from the write registers
	typedef struct packed {
		// wr3 bit 0
		logic rx_en;
		// wr5 bit 3
		logic tx_en;
		// wr1 bits 4:3, 01 first char, 10 every char
		logic [1:0] rx_int_mode;
		// wr1 bits 1 and 0
		logic tx_ie;
		logic ext_ie;
		// wr15 bit 3
		logic dcd_ie;
		// wr9 bit 3, master interrupt enable
		logic mie;
		time_const_t time_const;
	} chan_ctrl_t;

	// single clock strobes from bus accesses
	typedef struct packed {
		logic chan_reset;
		logic reset_ext;
		logic reset_tx_ip;
		logic rx_int_next;
		logic data_write;
		logic data_read;
	} chan_cmd_t;

	// pending sources as seen in rr3
	typedef struct packed {
		logic rx;
		logic tx;
		logic ext;
	} irq_pend_t;

	// rr0 bit positions
	localparam int unsigned RR0_RX_AVAIL = 0;
	localparam int unsigned RR0_TX_EMPTY = 2;
	localparam int unsigned RR0_DCD = 3;

endpackage

`default_nettype wire
